/* files.f */
common/vchan_pkg.sv
hw/stream_buffer.sv
hw/vchan_demux.sv
hw/packet_arbiter.sv
hw/vchan_mux.sv
dv/vchan_sva.sv
dv/vchan_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vchan_mux testbench with Verilator.
# Exits non-zero when the build, the run or the log check fails.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=vchan_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module vchan_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "test passed" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

/* dv/vchan_tb.sv */
// vchan_tb
// Testbench for the virtual-channel stream multiplexer.
// Random packets go out through mux_in and come back through the
// channel ports. A monitor checks every transfer against expected queues.

`default_nettype none

module vchan_tb;

    import vchan_pkg::*;

    // ============================================================
    // run constants
    // ============================================================

    localparam int unsigned SEED = 32'hf7b29677;
    localparam int MAX_LEN = 4;
    localparam int ROUTE_PKTS = 200;
    localparam int STALL_PKTS = 100;
    localparam int RET_PKTS = 100;
    localparam int FAIR_PKTS = 30;
    localparam int RET_STALL_PKTS = 60;
    // upper bound on beats over all tests
    localparam int TOTAL_BEATS = MAX_LEN * (ROUTE_PKTS + STALL_PKTS)
        + NUM_PORTS * (MAX_LEN * (RET_PKTS + RET_STALL_PKTS) + FAIR_PKTS);
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_BEATS + 200;

    logic        clk;
    logic        reset_n;
    vchan_beat_t mux_in_beat;
    logic        mux_in_valid;
    logic        mux_in_ready;
    vchan_beat_t demux_out_beat [NUM_PORTS];
    port_vec_t   demux_out_valid;
    port_vec_t   demux_out_ready;
    vchan_beat_t demux_in_beat [NUM_PORTS];
    port_vec_t   demux_in_valid;
    port_vec_t   demux_in_ready;
    vchan_beat_t mux_out_beat;
    logic        mux_out_valid;
    logic        mux_out_ready;

    // expected beats, outbound per destination, return per source
    vchan_beat_t out_q [NUM_PORTS][$];
    vchan_beat_t ret_q [NUM_PORTS][$];

    bit out_stall = 1'b0;
    bit ret_stall = 1'b0;
    bit fair_mode = 1'b0;
    bit pkt_open = 1'b0;
    int open_src = 0;
    int prev_src = 0;
    int n_checks = 0;
    int n_fail = 0;
    int fail_mark = 0;
    int cycle_cnt = 0;

    vchan_mux UUT
    (
        .clk(clk),
        .reset_n(reset_n),
        .mux_in_beat(mux_in_beat),
        .mux_in_valid(mux_in_valid),
        .mux_in_ready(mux_in_ready),
        .demux_out_beat(demux_out_beat),
        .demux_out_valid(demux_out_valid),
        .demux_out_ready(demux_out_ready),
        .demux_in_beat(demux_in_beat),
        .demux_in_valid(demux_in_valid),
        .demux_in_ready(demux_in_ready),
        .mux_out_beat(mux_out_beat),
        .mux_out_valid(mux_out_valid),
        .mux_out_ready(mux_out_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ============================================================
    // reference model and helpers
    // ============================================================

    // destination port named by user, port 0 when out of range
    function automatic int expected_port(input logic [USER_W-1:0] user);
        return (int'(user) < NUM_PORTS) ? int'(user) : 0;
    endfunction

    task automatic check(input bit ok, input string what);
        n_checks++;
        assert (ok)
        else
        begin
            n_fail++;
            $display("FAIL %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, n_fail - fail_mark);
        fail_mark = n_fail;
    endtask

    task automatic send_outbound(input int n_pkts);
        int len;
        logic [USER_W-1:0] dest;
        for (int k = 0; k < n_pkts; k++)
        begin
            len = 1 + int'($urandom % MAX_LEN);
            dest = USER_W'($urandom);
            for (int b = 0; b < len; b++)
            begin
                @(negedge clk);
                // occasional idle cycle
                if ($urandom % 4 == 0)
                begin
                    mux_in_valid = 1'b0;
                    @(negedge clk);
                end
                mux_in_beat.data = $urandom;
                mux_in_beat.last = (b == len - 1);
                mux_in_beat.user = dest;
                mux_in_valid = 1'b1;
                do
                begin
                    @(posedge clk);
                end
                while (!mux_in_ready);
            end
        end
        @(negedge clk);
        mux_in_valid = 1'b0;
    endtask

    task automatic send_return(input int port, input int n_pkts, input bit single);
        int len;
        for (int k = 0; k < n_pkts; k++)
        begin
            len = single ? 1 : 1 + int'($urandom % MAX_LEN);
            for (int b = 0; b < len; b++)
            begin
                @(negedge clk);
                if (!single && ($urandom % 4 == 0))
                begin
                    demux_in_valid[port] = 1'b0;
                    @(negedge clk);
                end
                demux_in_beat[port].data = $urandom;
                demux_in_beat[port].last = (b == len - 1);
                // user is ignored on the way in
                demux_in_beat[port].user = USER_W'($urandom);
                demux_in_valid[port] = 1'b1;
                do
                begin
                    @(posedge clk);
                end
                while (!demux_in_ready[port]);
            end
        end
        @(negedge clk);
        demux_in_valid[port] = 1'b0;
    endtask

    // all ports send at once
    task automatic run_return(input int n_pkts, input bit single);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            automatic int port = p;
            fork
                send_return(port, n_pkts, single);
            join_none
        end
        wait fork;
    endtask

    task automatic wait_drain();
        int pending;
        do
        begin
            @(negedge clk);
            pending = 0;
            for (int p = 0; p < NUM_PORTS; p++)
                pending += out_q[p].size() + ret_q[p].size();
        end
        while (pending != 0);
        check(demux_out_valid == '0 && !mux_out_valid, "DUT still holds beats after drain");
    endtask

    // random back-pressure
    always @(negedge clk)
    begin
        for (int p = 0; p < NUM_PORTS; p++)
            demux_out_ready[p] = out_stall ? ($urandom % 4 != 0) : 1'b1;
        mux_out_ready = ret_stall ? ($urandom % 3 != 0) : 1'b1;
    end

    // ============================================================
    // compare process
    // ============================================================

    always @(posedge clk)
    begin
        vchan_beat_t want;
        int dst;
        int src;
        if (reset_n)
        begin
            dst = expected_port(mux_in_beat.user);
            // the selected buffer takes beats while it holds fewer than two
            if (mux_in_valid)
                check(mux_in_ready == (out_q[dst].size() < 2),
                    $sformatf("mux_in_ready %b with %0d beats held on port %0d",
                        mux_in_ready, out_q[dst].size(), dst));
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (demux_out_valid[p] && demux_out_ready[p])
                begin
                    if (out_q[p].size() == 0)
                        check(1'b0, $sformatf("unexpected beat on port %0d", p));
                    else
                    begin
                        want = out_q[p].pop_front();
                        check(demux_out_beat[p] == want,
                            $sformatf("port %0d got %h, expected %h",
                                p, demux_out_beat[p], want));
                    end
                end
            end
            if (mux_in_valid && mux_in_ready)
                out_q[dst].push_back(mux_in_beat);

            if (mux_out_valid && mux_out_ready)
            begin
                src = int'(mux_out_beat.user);
                if (pkt_open)
                    check(src == open_src,
                        $sformatf("source %0d inside packet from %0d", src, open_src));
                if (fair_mode)
                    check(src == (prev_src + 1) % NUM_PORTS,
                        $sformatf("grant went to %0d after %0d", src, prev_src));
                if (src >= NUM_PORTS || ret_q[src].size() == 0)
                    check(1'b0, $sformatf("mux_out beat from source %0d not sent", src));
                else
                begin
                    want = ret_q[src].pop_front();
                    check(mux_out_beat == want,
                        $sformatf("mux_out got %h, expected %h", mux_out_beat, want));
                end
                pkt_open = !mux_out_beat.last;
                open_src = src;
                prev_src = src;
            end
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (demux_in_valid[p] && demux_in_ready[p])
                begin
                    want = demux_in_beat[p];
                    want.user = USER_W'(p);
                    ret_q[p].push_back(want);
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("run timed out after %0d cycles, the DUT stopped moving beats", cycle_cnt);
            $display("test failed");
            $finish;
        end
    end

    // ============================================================
    // test sequence
    // ============================================================

    initial
    begin
        void'($urandom(SEED));
        reset_n = 1'b0;
        mux_in_beat = '0;
        mux_in_valid = 1'b0;
        demux_out_ready = '1;
        demux_in_valid = '0;
        mux_out_ready = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++)
            demux_in_beat[p] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        @(negedge clk);
        check(demux_out_valid == '0, "demux_out_valid high after reset");
        check(!mux_out_valid, "mux_out_valid high after reset");
        report_test(1, "reset state");

        send_outbound(ROUTE_PKTS);
        wait_drain();
        report_test(2, "outbound routing");

        out_stall = 1'b1;
        send_outbound(STALL_PKTS);
        wait_drain();
        out_stall = 1'b0;
        report_test(3, "outbound back-pressure");

        run_return(RET_PKTS, 1'b0);
        wait_drain();
        report_test(4, "return merging");

        fair_mode = 1'b1;
        run_return(FAIR_PKTS, 1'b1);
        wait_drain();
        fair_mode = 1'b0;
        report_test(5, "round-robin fairness");

        ret_stall = 1'b1;
        run_return(RET_STALL_PKTS, 1'b0);
        wait_drain();
        ret_stall = 1'b0;
        report_test(6, "return back-pressure");

        $display("checks passed: %0d, checks failed: %0d", n_checks - n_fail, n_fail);
        if (n_fail == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/vchan_sva.sv */
// vchan_sva
// Concurrent checks on the vchan_mux output streams, attached by bind.
// Covers the hold rule, the idle state after reset and packet integrity.

`default_nettype none

module vchan_sva
(
    input wire                    clk,
    input wire                    reset_n,
    input vchan_pkg::vchan_beat_t demux_out_beat [vchan_pkg::NUM_PORTS],
    input vchan_pkg::port_vec_t   demux_out_valid,
    input vchan_pkg::port_vec_t   demux_out_ready,
    input vchan_pkg::vchan_beat_t mux_out_beat,
    input wire                    mux_out_valid,
    input wire                    mux_out_ready
);

    import vchan_pkg::*;

    logic              pkt_open;
    logic [USER_W-1:0] pkt_user;

    // packet on mux_out still waiting for its last beat
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            pkt_open <= 1'b0;
        else if (mux_out_valid && mux_out_ready)
        begin
            pkt_open <= !mux_out_beat.last;
            pkt_user <= mux_out_beat.user;
        end
    end

    // ============================================================
    // assertions
    // ============================================================

    a_mux_out_hold: assert property (@(posedge clk) disable iff (!reset_n)
        mux_out_valid && !mux_out_ready |=> mux_out_valid && $stable(mux_out_beat))
    else
        $error("mux_out beat changed while stalled");

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_hold
        a_demux_out_hold: assert property (@(posedge clk) disable iff (!reset_n)
            demux_out_valid[p] && !demux_out_ready[p]
            |=> demux_out_valid[p] && $stable(demux_out_beat[p]))
        else
            $error("demux_out beat changed while stalled");
    end

    a_reset_idle: assert property (@(posedge clk) !reset_n |=> !mux_out_valid)
    else
        $error("mux_out_valid high right after reset");

    // source stays the same for every beat of one packet
    a_user_steady: assert property (@(posedge clk) disable iff (!reset_n)
        pkt_open && mux_out_valid |-> mux_out_beat.user == pkt_user)
    else
        $error("mux_out user changed inside a packet");

endmodule

bind vchan_mux vchan_sva u_sva
(
    .clk(clk),
    .reset_n(reset_n),
    .demux_out_beat(demux_out_beat),
    .demux_out_valid(demux_out_valid),
    .demux_out_ready(demux_out_ready),
    .mux_out_beat(mux_out_beat),
    .mux_out_valid(mux_out_valid),
    .mux_out_ready(mux_out_ready)
);

`default_nettype wire

/* hw/vchan_mux.sv */
// vchan_mux
// Virtual-channel stream multiplexer, top level.
// Outbound: mux_in is split across the channel ports by user.
// Return: the channel ports are merged packet by packet into mux_out,
// with user naming the source port.

`default_nettype none

module vchan_mux
(
    input  wire                    clk,
    input  wire                    reset_n,

    // multiplexed input
    input  vchan_pkg::vchan_beat_t mux_in_beat,
    input  wire                    mux_in_valid,
    output logic                   mux_in_ready,

    // per-port outputs
    output vchan_pkg::vchan_beat_t demux_out_beat [vchan_pkg::NUM_PORTS],
    output vchan_pkg::port_vec_t   demux_out_valid,
    input  vchan_pkg::port_vec_t   demux_out_ready,

    // per-port return inputs
    input  vchan_pkg::vchan_beat_t demux_in_beat [vchan_pkg::NUM_PORTS],
    input  vchan_pkg::port_vec_t   demux_in_valid,
    output vchan_pkg::port_vec_t   demux_in_ready,

    // merged return output
    output vchan_pkg::vchan_beat_t mux_out_beat,
    output logic                   mux_out_valid,
    input  wire                    mux_out_ready
);

    // ============================================================
    // mux_in -> demux_out
    // ============================================================

    vchan_demux u_demux
    (
        .clk(clk),
        .reset_n(reset_n),

        .mux_in_beat(mux_in_beat),
        .mux_in_valid(mux_in_valid),
        .mux_in_ready(mux_in_ready),

        .demux_out_beat(demux_out_beat),
        .demux_out_valid(demux_out_valid),
        .demux_out_ready(demux_out_ready)
    );

    // ============================================================
    // demux_in -> mux_out
    // ============================================================

    packet_arbiter u_arbiter
    (
        .clk(clk),
        .reset_n(reset_n),

        .demux_in_beat(demux_in_beat),
        .demux_in_valid(demux_in_valid),
        .demux_in_ready(demux_in_ready),

        .mux_out_beat(mux_out_beat),
        .mux_out_valid(mux_out_valid),
        .mux_out_ready(mux_out_ready)
    );

endmodule

`default_nettype wire

/* hw/packet_arbiter.sv */
// packet_arbiter
// Return path. Merges the channel ports into one stream a whole
// packet at a time. Round-robin priority starts at the port after the
// one served last. Outgoing user carries the source port index.

`default_nettype none

module packet_arbiter
(
    input  wire                    clk,
    input  wire                    reset_n,

    input  vchan_pkg::vchan_beat_t demux_in_beat [vchan_pkg::NUM_PORTS],
    input  vchan_pkg::port_vec_t   demux_in_valid,
    output vchan_pkg::port_vec_t   demux_in_ready,

    output vchan_pkg::vchan_beat_t mux_out_beat,
    output logic                   mux_out_valid,
    input  wire                    mux_out_ready
);

    import vchan_pkg::*;

    // packet state
    logic              pkt_active;
    port_vec_t         grant_q;
    logic [PORT_W-1:0] last_port;

    // round-robin pick
    logic              pick_valid;
    logic [PORT_W-1:0] pick_idx;
    port_vec_t         pick_mask;

    logic [PORT_W-1:0] cur_idx;
    port_vec_t         grant;

    vchan_beat_t       buf_in_beat;
    logic              buf_in_valid;
    logic              buf_in_ready;
    logic              xfer;

    // ============================================================
    // round-robin search
    // ============================================================

    always_comb
    begin
        int cand;

        pick_valid = 1'b0;
        pick_idx = '0;
        cand = 0;
        // first valid port after last_port, wrapping around
        for (int i = 1; i <= NUM_PORTS; i++)
        begin
            cand = (int'(last_port) + i) % NUM_PORTS;
            if (!pick_valid && demux_in_valid[cand])
            begin
                pick_valid = 1'b1;
                pick_idx = PORT_W'(cand);
            end
        end

        pick_mask = '0;
        pick_mask[pick_idx] = pick_valid;
    end

    // held grant wins while a packet is open
    assign cur_idx = pkt_active ? last_port : pick_idx;
    assign grant = pkt_active ? grant_q : pick_mask;

    // ============================================================
    // forward granted port
    // ============================================================

    always_comb
    begin
        buf_in_beat = demux_in_beat[cur_idx];
        buf_in_beat.user = USER_W'(cur_idx);
    end

    assign buf_in_valid = |(grant & demux_in_valid);
    assign demux_in_ready = grant & {NUM_PORTS{buf_in_ready}};
    assign xfer = buf_in_valid && buf_in_ready;

    // grant is taken on pick, dropped after the last beat
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pkt_active <= 1'b0;
            grant_q <= '0;
            last_port <= PORT_W'(NUM_PORTS - 1);
        end
        else if (pkt_active)
        begin
            if (xfer && buf_in_beat.last)
            begin
                pkt_active <= 1'b0;
                grant_q <= '0;
            end
        end
        else if (pick_valid)
        begin
            last_port <= pick_idx;
            // single-beat packet that goes straight through stays idle
            if (!(xfer && buf_in_beat.last))
            begin
                pkt_active <= 1'b1;
                grant_q <= pick_mask;
            end
        end
    end

    stream_buffer
    #(
        .beat_t(vchan_beat_t)
    )
    u_out_buf
    (
        .clk(clk),
        .reset_n(reset_n),

        .in_beat(buf_in_beat),
        .in_valid(buf_in_valid),
        .in_ready(buf_in_ready),

        .out_beat(mux_out_beat),
        .out_valid(mux_out_valid),
        .out_ready(mux_out_ready)
    );

endmodule

`default_nettype wire

/* hw/vchan_demux.sv */
// vchan_demux
// Outbound path. Each beat of the multiplexed input names its
// destination port in user; out-of-range values go to port 0.
// Every port has its own two-entry stream buffer.

`default_nettype none

module vchan_demux
(
    input  wire                    clk,
    input  wire                    reset_n,

    input  vchan_pkg::vchan_beat_t mux_in_beat,
    input  wire                    mux_in_valid,
    output logic                   mux_in_ready,

    output vchan_pkg::vchan_beat_t demux_out_beat [vchan_pkg::NUM_PORTS],
    output vchan_pkg::port_vec_t   demux_out_valid,
    input  vchan_pkg::port_vec_t   demux_out_ready
);

    import vchan_pkg::*;

    logic [PORT_W-1:0] port_sel;
    port_vec_t         in_sel;
    port_vec_t         buf_valid;
    port_vec_t         buf_ready;

    // ============================================================
    // port decode
    // ============================================================

    // fall back to port 0 when user is out of range
    assign port_sel = (mux_in_beat.user < NUM_PORTS) ? PORT_W'(mux_in_beat.user) : '0;

    always_comb
    begin
        in_sel = '0;
        in_sel[port_sel] = 1'b1;
    end

    assign buf_valid = in_sel & {NUM_PORTS{mux_in_valid}};

    // a stalled selected port blocks the whole input
    assign mux_in_ready = buf_ready[port_sel];

    // ============================================================
    // per-port buffers
    // ============================================================

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_port
        stream_buffer
        #(
            .beat_t(vchan_beat_t)
        )
        u_buf
        (
            .clk(clk),
            .reset_n(reset_n),

            .in_beat(mux_in_beat),
            .in_valid(buf_valid[p]),
            .in_ready(buf_ready[p]),

            .out_beat(demux_out_beat[p]),
            .out_valid(demux_out_valid[p]),
            .out_ready(demux_out_ready[p])
        );
    end

endmodule

`default_nettype wire

/* hw/stream_buffer.sv */
// stream_buffer
// Two-entry valid/ready FIFO for any packed payload type.
// Output is driven from registers only, so out_ready never reaches
// in_ready combinationally. Sustains one beat per cycle.

`default_nettype none

module stream_buffer
#(
    parameter type beat_t = vchan_pkg::vchan_beat_t
)
(
    input  wire   clk,
    input  wire   reset_n,

    input  beat_t in_beat,
    input  wire   in_valid,
    output logic  in_ready,

    output beat_t out_beat,
    output logic  out_valid,
    input  wire   out_ready
);

    // storage, two slots
    beat_t mem [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    logic push;
    logic pop;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    // flags come straight from the count register
    assign in_ready = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_beat = mem[rd_ptr];

    // ============================================================
    // pointers and occupancy
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;

            case ({push, pop})
                2'b10: count <= count + 2'd1;
                2'b01: count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // payload write
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_beat;
    end

endmodule

`default_nettype wire

/* common/vchan_pkg.sv */
// vchan_pkg
// Shared definitions for the virtual-channel stream multiplexer:
// port count, field widths, the stream beat and the per-port mask type.

`default_nettype none

package vchan_pkg;

    // ============================================================
    // sizes
    // ============================================================

    // number of channel ports
    localparam int NUM_PORTS = 3;

    // width of a port index
    localparam int PORT_W = $clog2(NUM_PORTS);

    // payload width
    localparam int DATA_W = 32;

    // user carries a port index, so same width.
    // value 3 is encodable but out of range
    localparam int USER_W = PORT_W;

    // ============================================================
    // stream types
    // ============================================================

    // one beat of a stream
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        logic [USER_W-1:0] user;
    } vchan_beat_t;

    // one bit per channel port
    typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

`default_nettype wire
